// File: rtl/cpu_pkg.sv
package cpu_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int XLEN = 32;                    // data and address width
	localparam int REG_COUNT = 16;
	localparam int REG_AW = $clog2(REG_COUNT);   // register index width

	// ------------------------------
	// encodings
	// ------------------------------
	typedef enum logic [7:0] {
		OP_NOP     = 8'h00,
		OP_ADD_RR  = 8'h01,
		OP_SUB_RR  = 8'h02,
		OP_AND_RR  = 8'h03,
		OP_OR_RR   = 8'h04,
		OP_EOR_RR  = 8'h05,
		OP_CMP_RR  = 8'h06,
		OP_ADD_IMM = 8'h07,
		OP_LDI     = 8'h08,
		OP_LD      = 8'h09,
		OP_ST      = 8'h0A,
		OP_BEQ     = 8'h10,
		OP_BNE     = 8'h11,
		OP_BCS     = 8'h12,
		OP_BCC     = 8'h13,
		OP_BMI     = 8'h14,
		OP_BPL     = 8'h15,
		OP_BVS     = 8'h16,
		OP_BVC     = 8'h17,
		OP_BLT     = 8'h18,
		OP_BGE     = 8'h19,
		OP_BRA     = 8'h1A
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		S_RESET,
		S_IFETCH,
		S_DECODE,
		S_EXEC,
		S_MEM
	} state_e;

	// ------------------------------
	// bundles
	// ------------------------------
	typedef struct packed {
		logic n;
		logic v;
		logic z;
		logic c;
	} flags_t;

	typedef struct packed {
		opcode_e           opcode;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] ra;
		logic [REG_AW-1:0] rb;
		logic [XLEN-1:0]   imm;        // sign-extended
		alu_op_e           alu_op;
		logic              use_imm;
		logic              writes_reg;
		logic              writes_flags;
		logic              is_load;
		logic              is_store;
		logic              is_branch;
	} decoded_t;

	typedef struct packed {
		logic            valid;        // one-cycle request pulse
		logic            we;
		logic [XLEN-1:0] adr;
		logic [XLEN-1:0] wdat;
	} bus_req_t;

	typedef struct packed {
		logic            done;
		logic [XLEN-1:0] rdat;
	} bus_rsp_t;

endpackage

// File: rtl/cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode import cpu_pkg::*; (
	input  logic [XLEN-1:0] ir_i,
	output decoded_t        dec_o
);

	opcode_e op;
	logic    known;

	always_comb begin
		op = opcode_e'(ir_i[7:0]);
		known = 1'b1;
		dec_o = '0;
		dec_o.rt = ir_i[11:8];
		dec_o.ra = ir_i[15:12];
		dec_o.rb = ir_i[19:16];
		dec_o.imm = {{16{ir_i[31]}}, ir_i[31:16]};

		// instruction class
		case (op)
			OP_NOP: ;
			OP_ADD_RR, OP_SUB_RR, OP_AND_RR, OP_OR_RR, OP_EOR_RR: begin
				dec_o.writes_reg = 1'b1;
				dec_o.writes_flags = 1'b1;
			end
			OP_CMP_RR: dec_o.writes_flags = 1'b1;   // flags only, no write-back
			OP_ADD_IMM: begin
				dec_o.use_imm = 1'b1;
				dec_o.writes_reg = 1'b1;
				dec_o.writes_flags = 1'b1;
			end
			OP_LDI: begin
				dec_o.use_imm = 1'b1;
				dec_o.writes_reg = 1'b1;
			end
			OP_LD: begin
				dec_o.use_imm = 1'b1;
				dec_o.writes_reg = 1'b1;
				dec_o.is_load = 1'b1;
			end
			OP_ST: begin
				dec_o.use_imm = 1'b1;
				dec_o.is_store = 1'b1;
				dec_o.rb = ir_i[11:8];          // store data comes out of port b
			end
			OP_BEQ, OP_BNE, OP_BCS, OP_BCC, OP_BMI, OP_BPL,
			OP_BVS, OP_BVC, OP_BLT, OP_BGE, OP_BRA: dec_o.is_branch = 1'b1;
			default: known = 1'b0;
		endcase

		// alu function
		case (op)
			OP_SUB_RR, OP_CMP_RR: dec_o.alu_op = ALU_SUB;
			OP_AND_RR: dec_o.alu_op = ALU_AND;
			OP_OR_RR:  dec_o.alu_op = ALU_OR;
			OP_EOR_RR: dec_o.alu_op = ALU_EOR;
			OP_LDI:    dec_o.alu_op = ALU_PASS_B;
			default:   dec_o.alu_op = ALU_ADD;
		endcase

		dec_o.opcode = known ? op : OP_NOP;      // unknown codes fall through as nop
	end

endmodule

// File: rtl/cpu_regfile.sv
`timescale 1ns/1ps

module cpu_regfile import cpu_pkg::*; (
	input  logic              clk,
	input  logic              rst_i,
	input  logic [REG_AW-1:0] ra_i,
	input  logic [REG_AW-1:0] rb_i,
	input  logic              we_i,
	input  logic [REG_AW-1:0] rt_i,
	input  logic [XLEN-1:0]   wdata_i,
	output logic [XLEN-1:0]   rdata_a_o,
	output logic [XLEN-1:0]   rdata_b_o
);

	logic [XLEN-1:0] regs [REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we_i && rt_i != '0) begin   // r0 is hard-wired
			regs[rt_i] <= wdata_i;
		end
	end

	// r0 is cleared on reset and never written, so it reads zero
	assign rdata_a_o = regs[ra_i];
	assign rdata_b_o = regs[rb_i];

endmodule

// File: rtl/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu import cpu_pkg::*; (
	input  alu_op_e         op_i,
	input  logic [XLEN-1:0] a_i,
	input  logic [XLEN-1:0] b_i,
	input  flags_t          flags_in_i,
	output logic [XLEN-1:0] result_o,
	output flags_t          flags_o
);

	logic [XLEN:0] sum;
	logic [XLEN:0] diff;

	assign sum = {1'b0, a_i} + {1'b0, b_i};
	assign diff = {1'b0, a_i} + {1'b0, ~b_i} + 1'b1;   // carry out set means no borrow

	always_comb begin
		flags_o = flags_in_i;                      // logic ops keep c and v
		case (op_i)
			ALU_ADD: begin
				result_o = sum[XLEN-1:0];
				flags_o.c = sum[XLEN];
				flags_o.v = (a_i[XLEN-1] == b_i[XLEN-1]) && (sum[XLEN-1] != a_i[XLEN-1]);
			end
			ALU_SUB: begin
				result_o = diff[XLEN-1:0];
				flags_o.c = diff[XLEN];
				flags_o.v = (a_i[XLEN-1] != b_i[XLEN-1]) && (diff[XLEN-1] != a_i[XLEN-1]);
			end
			ALU_AND: result_o = a_i & b_i;
			ALU_OR:  result_o = a_i | b_i;
			ALU_EOR: result_o = a_i ^ b_i;
			default: result_o = b_i;               // pass b, used by ldi
		endcase

		// n and z follow every result
		flags_o.n = result_o[XLEN-1];
		flags_o.z = (result_o == '0);
	end

endmodule

// File: rtl/cpu_cond.sv
`timescale 1ns/1ps

module cpu_cond import cpu_pkg::*; (
	input  logic            clk,
	input  logic            rst_i,
	input  logic            flags_we_i,
	input  flags_t          flags_i,
	input  opcode_e         opcode_i,
	input  logic [XLEN-1:0] pc_i,
	input  logic [XLEN-1:0] imm_i,
	output flags_t          flags_o,
	output logic            taken_o,
	output logic [XLEN-1:0] target_o
);

	flags_t flags;

	// ------------------------------
	// status flags
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst_i)
			flags <= '0;
		else if (flags_we_i)
			flags <= flags_i;
	end

	assign flags_o = flags;

	// ------------------------------
	// branch evaluation
	// ------------------------------
	always_comb begin
		case (opcode_i)
			OP_BEQ:  taken_o = flags.z;
			OP_BNE:  taken_o = !flags.z;
			OP_BCS:  taken_o = flags.c;
			OP_BCC:  taken_o = !flags.c;
			OP_BMI:  taken_o = flags.n;
			OP_BPL:  taken_o = !flags.n;
			OP_BVS:  taken_o = flags.v;
			OP_BVC:  taken_o = !flags.v;
			OP_BLT:  taken_o = flags.n ^ flags.v;     // signed less than
			OP_BGE:  taken_o = !(flags.n ^ flags.v);
			OP_BRA:  taken_o = 1'b1;
			default: taken_o = 1'b0;
		endcase
	end

	// immediate counts words, relative to the next instruction
	assign target_o = pc_i + XLEN'(4) + {imm_i[XLEN-3:0], 2'b00};

endmodule

// File: rtl/cpu_bus_master.sv
`timescale 1ns/1ps

module cpu_bus_master import cpu_pkg::*; (
	input  logic            clk,
	input  logic            rst_i,
	input  bus_req_t        req_i,
	input  logic            ack_i,
	input  logic [XLEN-1:0] dat_i,
	output bus_rsp_t        rsp_o,
	output logic            cyc_o,
	output logic            stb_o,
	output logic            we_o,
	output logic [XLEN-1:0] adr_o,
	output logic [XLEN-1:0] dat_o
);

	logic            active;    // transfer open on the bus
	logic            we;
	logic [XLEN-1:0] adr;
	logic [XLEN-1:0] wdat;

	// strobes and write enable
	always_ff @(posedge clk) begin
		if (rst_i) begin
			active <= 1'b0;
			we <= 1'b0;
		end else if (active && ack_i) begin
			active <= 1'b0;                        // drop the cycle after ack
			we <= 1'b0;
		end else if (req_i.valid && !active) begin
			active <= 1'b1;
			we <= req_i.we;
		end
	end

	// address and data held for the whole transfer
	always_ff @(posedge clk) begin
		if (req_i.valid && !active) begin
			adr <= req_i.adr;
			wdat <= req_i.wdat;
		end
	end

	assign cyc_o = active;
	assign stb_o = active;
	assign we_o = we;
	assign adr_o = adr;
	assign dat_o = wdat;

	assign rsp_o.done = active & ack_i;
	assign rsp_o.rdat = dat_i;

endmodule

// File: rtl/cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer import cpu_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            rst_i,
	input  decoded_t        dec_i,
	input  logic            branch_taken_i,
	input  logic [XLEN-1:0] branch_target_i,
	input  logic [XLEN-1:0] alu_result_i,
	input  logic [XLEN-1:0] rdata_a_i,
	input  logic [XLEN-1:0] rdata_b_i,
	input  bus_rsp_t        bus_rsp_i,
	output logic [XLEN-1:0] ir_o,
	output logic [XLEN-1:0] pc_o,
	output bus_req_t        bus_req_o,
	output logic            reg_we_o,
	output logic [XLEN-1:0] reg_wdata_o,
	output logic            flags_we_o,
	output state_e          state_o
);

	state_e          state;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] ir;
	logic            busy;       // request issued, done not yet seen
	logic [XLEN-1:0] ea;
	logic            mem_op;

	assign ea = alu_result_i;                     // effective address, alu sum of a and imm
	assign mem_op = dec_i.is_load | dec_i.is_store;

	// ------------------------------
	// state, pc and ir
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= S_RESET;
			pc <= RESET_PC;
			ir <= '0;                              // decodes as nop
			busy <= 1'b0;
		end else begin
			if (bus_req_o.valid)
				busy <= 1'b1;
			else if (bus_rsp_i.done)
				busy <= 1'b0;

			case (state)
				S_RESET: state <= S_IFETCH;
				S_IFETCH: begin
					if (bus_rsp_i.done) begin
						ir <= bus_rsp_i.rdat;
						state <= S_DECODE;
					end
				end
				S_DECODE: state <= S_EXEC;
				S_EXEC: begin
					if (dec_i.is_branch && branch_taken_i)
						pc <= branch_target_i;
					else
						pc <= pc + XLEN'(4);
					state <= mem_op ? S_MEM : S_IFETCH;
				end
				S_MEM: begin
					if (bus_rsp_i.done)
						state <= S_IFETCH;
				end
				default: state <= S_RESET;
			endcase
		end
	end

	// ------------------------------
	// bus requests
	// ------------------------------
	always_comb begin
		bus_req_o = '0;
		case (state)
			S_IFETCH: begin
				bus_req_o.valid = !busy;             // once per fetch
				bus_req_o.adr = pc;
			end
			S_EXEC: begin
				bus_req_o.valid = mem_op;
				bus_req_o.we = dec_i.is_store;
				bus_req_o.adr = ea;
				bus_req_o.wdat = rdata_b_i;           // rt routed onto port b
			end
			default: ;
		endcase
	end

	// write-back, loads land when the data returns
	assign reg_we_o = (state == S_EXEC && dec_i.writes_reg && !dec_i.is_load) ||
		(state == S_MEM && bus_rsp_i.done && dec_i.is_load);
	assign reg_wdata_o = (state == S_MEM) ? bus_rsp_i.rdat : alu_result_i;
	assign flags_we_o = (state == S_EXEC) && dec_i.writes_flags;

	assign ir_o = ir;
	assign pc_o = pc;
	assign state_o = state;

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            rst_i,
	input  logic            ack_i,
	input  logic [XLEN-1:0] dat_i,
	output logic            cyc_o,
	output logic            stb_o,
	output logic            we_o,
	output logic [XLEN-1:0] adr_o,
	output logic [XLEN-1:0] dat_o
);

	decoded_t        dec;
	logic [XLEN-1:0] ir;
	logic [XLEN-1:0] pc;
	bus_req_t        bus_req;
	bus_rsp_t        bus_rsp;
	logic            reg_we;
	logic [XLEN-1:0] reg_wdata;
	logic            flags_we;
	logic [XLEN-1:0] rdata_a;
	logic [XLEN-1:0] rdata_b;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_result;
	flags_t          alu_flags;
	flags_t          flags;
	logic            taken;
	logic [XLEN-1:0] target;

	assign alu_b = dec.use_imm ? dec.imm : rdata_b;   // operand b select

	cpu_sequencer #(
		.RESET_PC(RESET_PC)
	) u_seq (
		.clk(clk),
		.rst_i(rst_i),
		.dec_i(dec),
		.branch_taken_i(taken),
		.branch_target_i(target),
		.alu_result_i(alu_result),
		.rdata_a_i(rdata_a),
		.rdata_b_i(rdata_b),
		.bus_rsp_i(bus_rsp),
		.ir_o(ir),
		.pc_o(pc),
		.bus_req_o(bus_req),
		.reg_we_o(reg_we),
		.reg_wdata_o(reg_wdata),
		.flags_we_o(flags_we),
		.state_o()
	);

	cpu_decode u_dec (
		.ir_i(ir),
		.dec_o(dec)
	);

	cpu_regfile u_rf (
		.clk(clk),
		.rst_i(rst_i),
		.ra_i(dec.ra),
		.rb_i(dec.rb),
		.we_i(reg_we),
		.rt_i(dec.rt),
		.wdata_i(reg_wdata),
		.rdata_a_o(rdata_a),
		.rdata_b_o(rdata_b)
	);

	cpu_alu u_alu (
		.op_i(dec.alu_op),
		.a_i(rdata_a),
		.b_i(alu_b),
		.flags_in_i(flags),
		.result_o(alu_result),
		.flags_o(alu_flags)
	);

	cpu_cond u_cond (
		.clk(clk),
		.rst_i(rst_i),
		.flags_we_i(flags_we),
		.flags_i(alu_flags),
		.opcode_i(dec.opcode),
		.pc_i(pc),
		.imm_i(dec.imm),
		.flags_o(flags),
		.taken_o(taken),
		.target_o(target)
	);

	cpu_bus_master u_bus (
		.clk(clk),
		.rst_i(rst_i),
		.req_i(bus_req),
		.ack_i(ack_i),
		.dat_i(dat_i),
		.rsp_o(bus_rsp),
		.cyc_o(cyc_o),
		.stb_o(stb_o),
		.we_o(we_o),
		.adr_o(adr_o),
		.dat_o(dat_o)
	);

endmodule

// File: test/cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions (
	input logic        clk,
	input logic        rst_i,
	input logic        cyc_o,
	input logic        stb_o,
	input logic        we_o,
	input logic        ack_i,
	input logic [31:0] adr_o,
	input logic [31:0] dat_o
);

	// strobe and cycle move as one
	a_stb_cyc: assert property (@(posedge clk) disable iff (rst_i) stb_o == cyc_o)
		else $error("stb_o differs from cyc_o");

	a_hold: assert property (@(posedge clk) disable iff (rst_i)
		(stb_o && !ack_i) |=> (stb_o && $stable(adr_o) && $stable(dat_o)))
		else $error("request changed before ack");

	a_we_stb: assert property (@(posedge clk) disable iff (rst_i) we_o |-> stb_o)
		else $error("we_o high without stb_o");

endmodule

bind cpu_top cpu_assertions u_assertions (
	.clk(clk),
	.rst_i(rst_i),
	.cyc_o(cyc_o),
	.stb_o(stb_o),
	.we_o(we_o),
	.ack_i(ack_i),
	.adr_o(adr_o),
	.dat_o(dat_o)
);

// File: test/tb_checker.sv
`timescale 1ns/1ps

module tb_checker import cpu_pkg::*; #(
	parameter logic [31:0] RESET_PC = '0,
	parameter int MEM_WORDS = 1024
) (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic        ack_i,
	input  logic [31:0] adr_i,
	input  logic [31:0] wdat_i,
	output logic        done_o,
	output int          err_count_o
);

	logic [31:0] model_mem [MEM_WORDS];
	logic [31:0] regs [16];
	logic        n_f, v_f, z_f, c_f;
	logic [31:0] pc;
	logic [31:0] final_adr;
	logic [31:0] exp_adr;
	logic [31:0] exp_wdat;
	logic        exp_we;
	logic        mem_pending;   // load or store still owed
	logic [3:0]  load_rt;
	logic        active;
	int          final_seen;
	int          fetches;
	int          stores;
	int          test_errs;
	string       name;

	initial begin
		active = 1'b0;
		done_o = 1'b0;
		err_count_o = 0;
	end

	task automatic start_test(input string tname, input logic [31:0] last_adr);
		name = tname;
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		{n_f, v_f, z_f, c_f} = 4'b0000;
		pc = RESET_PC;
		final_adr = last_adr;
		mem_pending = 1'b0;
		final_seen = 0;
		fetches = 0;
		stores = 0;
		test_errs = 0;
		done_o = 1'b0;
		active = 1'b1;
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s %s: expected %h, actual %h", name, what, exp, act);
			test_errs++;
			err_count_o++;
		end
	endtask

	task automatic write_reg(input logic [3:0] rt, input logic [31:0] val);
		if (rt != 4'd0)
			regs[rt] = val;
	endtask

	// ------------------------------
	// instruction set model
	// ------------------------------
	task automatic execute(input logic [31:0] word);
		logic [7:0]  op;
		logic [3:0]  rt;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] r;
		logic [32:0] wide;
		logic [32:0] ext;
		logic        take;
		op = word[7:0];
		rt = word[11:8];
		a = regs[word[15:12]];
		b = regs[word[19:16]];
		imm = {{16{word[31]}}, word[31:16]};
		r = '0;
		take = 1'b0;
		case (op)
			OP_ADD_RR, OP_ADD_IMM: begin
				if (op == OP_ADD_IMM)
					b = imm;
				wide = {1'b0, a} + {1'b0, b};
				ext = {a[31], a} + {b[31], b};   // exact signed sum
				r = wide[31:0];
				c_f = wide[32];
				v_f = ext[32] ^ ext[31];          // signed sum out of range
			end
			OP_SUB_RR, OP_CMP_RR: begin
				ext = {a[31], a} - {b[31], b};   // exact signed difference
				r = a - b;
				c_f = (a >= b);                  // set when nothing is borrowed
				v_f = ext[32] ^ ext[31];
			end
			OP_AND_RR: r = a & b;
			OP_OR_RR:  r = a | b;
			OP_EOR_RR: r = a ^ b;
			default: ;
		endcase
		case (op)
			OP_ADD_RR, OP_ADD_IMM, OP_SUB_RR, OP_CMP_RR, OP_AND_RR, OP_OR_RR, OP_EOR_RR: begin
				n_f = r[31];
				z_f = (r == '0);
				if (op != OP_CMP_RR)
					write_reg(rt, r);
			end
			OP_LDI: write_reg(rt, imm);
			OP_LD, OP_ST: begin
				mem_pending = 1'b1;
				exp_we = (op == OP_ST);
				exp_adr = a + imm;
				exp_wdat = regs[rt];
				load_rt = rt;
			end
			OP_BEQ: take = z_f;
			OP_BNE: take = !z_f;
			OP_BCS: take = c_f;
			OP_BCC: take = !c_f;
			OP_BMI: take = n_f;
			OP_BPL: take = !n_f;
			OP_BVS: take = v_f;
			OP_BVC: take = !v_f;
			OP_BLT: take = n_f ^ v_f;
			OP_BGE: take = !(n_f ^ v_f);
			OP_BRA: take = 1'b1;
			default: ;                           // unknown codes do nothing
		endcase
		pc = take ? pc + 32'd4 + imm * 32'd4 : pc + 32'd4;
	endtask

	// ------------------------------
	// bus traffic comparison
	// ------------------------------
	// sampled mid cycle, ack is known to land on the next rising edge
	always @(negedge clk) begin
		if (active && !rst_i && cyc_i && stb_i && ack_i) begin
			if (mem_pending) begin
				mem_pending = 1'b0;
				check_value("memory address", exp_adr, adr_i);
				check_value("write enable", {31'b0, exp_we}, {31'b0, we_i});
				if (exp_we) begin
					stores++;
					check_value("store data", exp_wdat, wdat_i);
					model_mem[exp_adr[11:2]] = exp_wdat;
				end else begin
					write_reg(load_rt, model_mem[exp_adr[11:2]]);
				end
			end else begin
				fetches++;
				check_value("fetch address", pc, adr_i);
				if (we_i) begin
					$display("test %s: instruction fetch was issued as a write", name);
					test_errs++;
					err_count_o++;
				end
				if (pc == final_adr)
					final_seen++;
				if (final_seen == 2) begin
					active = 1'b0;
					$display("test %s: %0d fetches, %0d stores, %0d errors", name,
						fetches, stores, test_errs);
					done_o = 1'b1;
				end else begin
					execute(model_mem[pc[11:2]]);
				end
			end
		end
	end

endmodule

// File: test/tb_top.sv
`timescale 1ns/1ps

module tb_top import cpu_pkg::*; ();

	localparam logic [31:0] RESET_PC = 32'h0000_0000;
	localparam int MEM_WORDS = 1024;
	localparam int PROG_LEN = 60;
	localparam logic [31:0] DATA_BASE = 32'h0000_0800;   // word 512
	localparam int NUM_TESTS = 3;
	localparam int TIMEOUT_NS = NUM_TESTS * PROG_LEN * 20 * 10 + NUM_TESTS * 20 * 10;

	logic        clk;
	logic        rst_i;
	logic        ack_i;
	logic [31:0] dat_i;
	logic        cyc_o;
	logic        stb_o;
	logic        we_o;
	logic [31:0] adr_o;
	logic [31:0] dat_o;

	logic [31:0] mem [MEM_WORDS];
	logic        pending;      // strobe seen, ack not yet given
	int          wait_left;
	logic        test_done;
	int          chk_errors;
	int          bench_errors;
	int          tests_failed;

	cpu_top #(
		.RESET_PC(RESET_PC)
	) uut (
		.clk(clk),
		.rst_i(rst_i),
		.ack_i(ack_i),
		.dat_i(dat_i),
		.cyc_o(cyc_o),
		.stb_o(stb_o),
		.we_o(we_o),
		.adr_o(adr_o),
		.dat_o(dat_o)
	);

	tb_checker #(
		.RESET_PC(RESET_PC),
		.MEM_WORDS(MEM_WORDS)
	) chk (
		.clk(clk),
		.rst_i(rst_i),
		.cyc_i(cyc_o),
		.stb_i(stb_o),
		.we_i(we_o),
		.ack_i(ack_i),
		.adr_i(adr_o),
		.wdat_i(dat_o),
		.done_o(test_done),
		.err_count_o(chk_errors)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ------------------------------
	// bus memory with wait states
	// ------------------------------
	always @(posedge clk) begin
		#1;
		if (rst_i) begin
			ack_i = 1'b0;
			pending = 1'b0;
		end else if (ack_i) begin
			ack_i = 1'b0;                       // strobes drop on this edge
		end else if (cyc_o && stb_o) begin
			if (!pending) begin
				pending = 1'b1;
				wait_left = int'($urandom_range(0, 3));
			end
			if (wait_left == 0) begin
				ack_i = 1'b1;
				dat_i = mem[adr_o[11:2]];
				if (we_o)
					mem[adr_o[11:2]] = dat_o;
				pending = 1'b0;
			end else begin
				wait_left = wait_left - 1;
			end
		end
	end

	// ------------------------------
	// program generation
	// ------------------------------
	function automatic logic [31:0] rr_word(opcode_e op, logic [3:0] rt, logic [3:0] ra,
		logic [3:0] rb);
		return {12'h000, rb, ra, rt, op};
	endfunction

	function automatic logic [31:0] imm_word(opcode_e op, logic [3:0] rt, logic [3:0] ra,
		logic [15:0] imm);
		return {imm, ra, rt, op};
	endfunction

	function automatic logic [31:0] random_instr(int kind, int idx);
		int          sel;
		int          max_off;
		logic [3:0]  rt;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [15:0] moff;
		opcode_e     rr_op;
		opcode_e     br_op;
		sel = int'($urandom_range(0, 99));
		rt = 4'($urandom_range(0, 14));         // r15 stays the data base
		ra = 4'($urandom_range(0, 15));
		rb = 4'($urandom_range(0, 15));
		moff = 16'($urandom_range(0, 63) * 4);
		rr_op = opcode_e'(8'($urandom_range(1, 6)));
		br_op = opcode_e'(8'($urandom_range(16, 26)));
		max_off = PROG_LEN - 2 - idx;
		if (max_off > 3)
			max_off = 3;
		case (kind)
			0: begin
				if (sel < 25) return imm_word(OP_LDI, rt, ra, 16'($urandom));
				if (sel < 40) return imm_word(OP_ADD_IMM, rt, ra, 16'($urandom));
				if (sel < 80) return rr_word(rr_op, rt, ra, rb);
				return imm_word(OP_ST, rt, 4'd15, moff);
			end
			1: begin
				if (sel < 35) return imm_word(OP_LD, 4'($urandom_range(1, 14)), 4'd15, moff);
				if (sel < 70) return imm_word(OP_ST, rt, 4'd15, moff);
				if (sel < 85) return imm_word(OP_LDI, rt, ra, 16'($urandom));
				return rr_word(OP_ADD_RR, rt, ra, rb);
			end
			default: begin
				if (sel < 30) return rr_word(OP_CMP_RR, rt, ra, rb);
				if (sel < 60)  // forward only, never past the last word
					return imm_word(br_op, 4'd0, 4'd0, 16'($urandom_range(0, max_off)));
				if (sel < 80) return imm_word(OP_LDI, rt, ra, 16'($urandom));
				if (sel < 90) return imm_word(OP_ADD_IMM, rt, ra, 16'($urandom));
				return rr_word(rr_op, rt, ra, rb);
			end
		endcase
	endfunction

	task automatic build_program(input int kind);
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = {~i[15:0], i[15:0]};           // fill tied to each address
		mem[0] = imm_word(OP_LDI, 4'd15, 4'd0, DATA_BASE[15:0]);
		for (int i = 1; i < PROG_LEN - 1; i++)
			mem[i] = random_instr(kind, i);
		mem[PROG_LEN-1] = imm_word(OP_BRA, 4'd0, 4'd0, 16'hFFFF);   // spin in place
		for (int j = 0; j < 64; j++)
			mem[DATA_BASE[11:2] + j] = $urandom;
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	task automatic run_test(input int kind, input string name);
		int errs_before;
		errs_before = chk_errors + bench_errors;
		@(posedge clk);
		#1 rst_i = 1'b1;
		build_program(kind);
		for (int i = 0; i < MEM_WORDS; i++)
			chk.model_mem[i] = mem[i];
		chk.start_test(name, RESET_PC + 32'(4 * (PROG_LEN - 1)));
		repeat (16) @(posedge clk);
		#1 rst_i = 1'b0;
		if (cyc_o) begin
			$display("test %s: cyc_o is high when reset ends", name);
			bench_errors++;
		end
		wait (test_done);
		if (chk_errors + bench_errors != errs_before)
			tests_failed++;
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		void'($urandom(37369));
		rst_i = 1'b1;
		ack_i = 1'b0;
		dat_i = '0;
		pending = 1'b0;
		wait_left = 0;
		bench_errors = 0;
		tests_failed = 0;
		run_test(0, "alu");
		run_test(1, "memory");
		run_test(2, "branch");
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS,
			NUM_TESTS - tests_failed, tests_failed, chk_errors + bench_errors);
		if (chk_errors + bench_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: build.f
rtl/cpu_pkg.sv
rtl/cpu_decode.sv
rtl/cpu_regfile.sv
rtl/cpu_alu.sv
rtl/cpu_cond.sv
rtl/cpu_bus_master.sv
rtl/cpu_sequencer.sv
rtl/cpu_top.sv
test/cpu_assertions.sv
test/tb_checker.sv
test/tb_top.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_top -f build.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
	exit 0
fi
exit 1
